/* logic/stream_pkg.sv */
package stream_pkg;

  // Input beat width.
  localparam int byte_width = 8;

  // Bytes per packed output word.
  localparam int word_bytes = 4;

  // Output word width.
  localparam int word_width = byte_width * word_bytes;

  // Peer sources sharing the merged bus.
  localparam int num_sources = 2;

  // Lane counter inside the upsizer.
  localparam int count_width = $clog2(word_bytes);

endpackage

/* logic/stream_upsizer.sv */
`timescale 1ns/1ps

module stream_upsizer (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic [stream_pkg::byte_width-1:0]    in_data,
  input  logic                                 in_valid,
  output logic                                 in_ready,
  input  logic                                 in_last,
  input  logic                                 in_user,
  output logic [stream_pkg::word_width-1:0]    out_data,
  output logic [stream_pkg::word_bytes-1:0]    out_keep,
  output logic                                 out_valid,
  input  logic                                 out_ready,
  output logic                                 out_last,
  output logic                                 out_user
);

  logic [stream_pkg::count_width-1:0] count;
  logic                               in_fire;
  logic                               lane_full;
  logic                               word_done;

  assign in_fire   = in_valid & in_ready;
  assign lane_full = (int'(count) == stream_pkg::word_bytes - 1);

  // Word closes on the top lane or on the packet end.
  assign word_done = in_fire & (in_last | lane_full);

  always_ff @(posedge clk) begin
    if (rst) begin
      count     <= '0;
      out_valid <= 1'b0;
      in_ready  <= 1'b0;
    end else begin
      if (in_fire) begin
        if (word_done) begin
          count <= '0;
        end else begin
          count <= count + 1'b1;
        end
      end

      if (word_done) begin
        out_valid <= 1'b1;
      end else if (out_ready) begin
        out_valid <= 1'b0;
      end

      // Input stalls while a finished word waits downstream.
      if (out_valid) begin
        in_ready <= out_ready;
      end else begin
        in_ready <= !word_done;
      end
    end
  end

  // Lane steering.
  always_ff @(posedge clk) begin
    if (in_fire) begin
      if (count == '0) begin
        out_data <= '0;
        out_keep <= '0;
      end
      for (int i = 0; i < stream_pkg::word_bytes; i++) begin
        if (int'(count) == i) begin
          out_data[i*stream_pkg::byte_width +: stream_pkg::byte_width] <= in_data;
          out_keep[i] <= 1'b1;
        end
      end
      if (word_done) begin
        out_last <= in_last;
        // tuser only counts on the closing beat of a packet.
        out_user <= in_last & in_user;
      end
    end
  end

  // Lanes fill from zero upward, so keep is a low run of ones.
  keep_contiguous: assert property (
    @(posedge clk) disable iff (rst)
    out_valid |-> (out_keep != '0) && ((out_keep & (out_keep + 1'b1)) == '0)
  );

  // A waiting word holds until taken.
  word_held: assert property (
    @(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_keep)
  );

endmodule

/* logic/packet_arbiter.sv */
`timescale 1ns/1ps

module packet_arbiter (
  input  logic                                        clk,
  input  logic                                        rst,
  input  logic [stream_pkg::word_width-1:0]           s0_data,
  input  logic [stream_pkg::word_bytes-1:0]           s0_keep,
  input  logic                                        s0_valid,
  output logic                                        s0_ready,
  input  logic                                        s0_last,
  input  logic                                        s0_user,
  input  logic [stream_pkg::word_width-1:0]           s1_data,
  input  logic [stream_pkg::word_bytes-1:0]           s1_keep,
  input  logic                                        s1_valid,
  output logic                                        s1_ready,
  input  logic                                        s1_last,
  input  logic                                        s1_user,
  output logic [stream_pkg::word_width-1:0]           m_data,
  output logic [stream_pkg::word_bytes-1:0]           m_keep,
  output logic                                        m_valid,
  input  logic                                        m_ready,
  output logic                                        m_last,
  output logic                                        m_user,
  output logic [$clog2(stream_pkg::num_sources)-1:0]  m_src
);

  logic [$clog2(stream_pkg::num_sources)-1:0] grant;
  logic                                       in_pkt;
  logic                                       other_valid;
  logic                                       last_fire;

  // Shared bus mux.
  assign m_data  = grant[0] ? s1_data  : s0_data;
  assign m_keep  = grant[0] ? s1_keep  : s0_keep;
  assign m_valid = grant[0] ? s1_valid : s0_valid;
  assign m_last  = grant[0] ? s1_last  : s0_last;
  assign m_user  = grant[0] ? s1_user  : s0_user;
  assign m_src   = grant;

  // Only the granted source sees ready.
  assign s0_ready = m_ready & ~grant[0];
  assign s1_ready = m_ready & grant[0];

  assign other_valid = grant[0] ? s0_valid : s1_valid;
  assign last_fire   = m_valid & m_ready & m_last;

  always_ff @(posedge clk) begin
    if (rst) begin
      grant  <= '0;
      in_pkt <= 1'b0;
    end else if (last_fire) begin
      in_pkt <= 1'b0;
      if (other_valid) begin
        grant <= ~grant;
      end
    end else if (m_valid) begin
      // Locked once a word is on the bus.
      in_pkt <= 1'b1;
    end else if (!in_pkt && other_valid) begin
      // Hand over from an idle grant holder.
      grant <= ~grant;
    end
  end

  grant_held_in_packet: assert property (
    @(posedge clk) disable iff (rst)
    in_pkt && !last_fire |=> $stable(grant)
  );

endmodule

/* logic/output_skid.sv */
`timescale 1ns/1ps

module output_skid (
  input  logic                                        clk,
  input  logic                                        rst,
  input  logic [stream_pkg::word_width-1:0]           in_data,
  input  logic [stream_pkg::word_bytes-1:0]           in_keep,
  input  logic                                        in_valid,
  output logic                                        in_ready,
  input  logic                                        in_last,
  input  logic                                        in_user,
  input  logic [$clog2(stream_pkg::num_sources)-1:0]  in_src,
  output logic [stream_pkg::word_width-1:0]           out_data,
  output logic [stream_pkg::word_bytes-1:0]           out_keep,
  output logic                                        out_valid,
  input  logic                                        out_ready,
  output logic                                        out_last,
  output logic                                        out_user,
  output logic [$clog2(stream_pkg::num_sources)-1:0]  out_src
);

  logic [stream_pkg::word_width-1:0]          spare_data;
  logic [stream_pkg::word_bytes-1:0]          spare_keep;
  logic                                       spare_valid;
  logic                                       spare_last;
  logic                                       spare_user;
  logic [$clog2(stream_pkg::num_sources)-1:0] spare_src;
  logic                                       ready_early;
  logic                                       load_main;

  // Ready drops only once both registers could be full.
  assign ready_early = out_ready | (~spare_valid & (~out_valid | ~in_valid));
  assign load_main   = out_ready | ~out_valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid   <= 1'b0;
      spare_valid <= 1'b0;
      in_ready    <= 1'b0;
    end else begin
      in_ready <= ready_early;
      if (in_ready) begin
        if (load_main) begin
          out_valid <= in_valid;
        end else begin
          spare_valid <= in_valid;
        end
      end else if (out_ready) begin
        out_valid   <= spare_valid;
        spare_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_ready) begin
      if (load_main) begin
        {out_data, out_keep, out_last, out_user, out_src} <=
          {in_data, in_keep, in_last, in_user, in_src};
      end else begin
        {spare_data, spare_keep, spare_last, spare_user, spare_src} <=
          {in_data, in_keep, in_last, in_user, in_src};
      end
    end else if (out_ready) begin
      {out_data, out_keep, out_last, out_user, out_src} <=
        {spare_data, spare_keep, spare_last, spare_user, spare_src};
    end
  end

  out_stable: assert property (
    @(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_data)
  );

endmodule

/* logic/dual_stream_merge.sv */
`timescale 1ns/1ps

module dual_stream_merge (
  input  logic                                        clk,
  input  logic                                        rst,
  input  logic [stream_pkg::byte_width-1:0]           src0_data,
  input  logic                                        src0_valid,
  output logic                                        src0_ready,
  input  logic                                        src0_last,
  input  logic                                        src0_user,
  input  logic [stream_pkg::byte_width-1:0]           src1_data,
  input  logic                                        src1_valid,
  output logic                                        src1_ready,
  input  logic                                        src1_last,
  input  logic                                        src1_user,
  output logic [stream_pkg::word_width-1:0]           out_data,
  output logic [stream_pkg::word_bytes-1:0]           out_keep,
  output logic                                        out_valid,
  input  logic                                        out_ready,
  output logic                                        out_last,
  output logic                                        out_user,
  output logic [$clog2(stream_pkg::num_sources)-1:0]  out_src
);

  // Upsized word streams.
  logic [stream_pkg::word_width-1:0]          up0_data;
  logic [stream_pkg::word_bytes-1:0]          up0_keep;
  logic                                       up0_valid;
  logic                                       up0_ready;
  logic                                       up0_last;
  logic                                       up0_user;
  logic [stream_pkg::word_width-1:0]          up1_data;
  logic [stream_pkg::word_bytes-1:0]          up1_keep;
  logic                                       up1_valid;
  logic                                       up1_ready;
  logic                                       up1_last;
  logic                                       up1_user;

  // Arbitrated stream into the output stage.
  logic [stream_pkg::word_width-1:0]          arb_data;
  logic [stream_pkg::word_bytes-1:0]          arb_keep;
  logic                                       arb_valid;
  logic                                       arb_ready;
  logic                                       arb_last;
  logic                                       arb_user;
  logic [$clog2(stream_pkg::num_sources)-1:0] arb_src;

  stream_upsizer upsizer0_i (
    .clk       (clk),
    .rst       (rst),
    .in_data   (src0_data),
    .in_valid  (src0_valid),
    .in_ready  (src0_ready),
    .in_last   (src0_last),
    .in_user   (src0_user),
    .out_data  (up0_data),
    .out_keep  (up0_keep),
    .out_valid (up0_valid),
    .out_ready (up0_ready),
    .out_last  (up0_last),
    .out_user  (up0_user)
  );

  stream_upsizer upsizer1_i (
    .clk       (clk),
    .rst       (rst),
    .in_data   (src1_data),
    .in_valid  (src1_valid),
    .in_ready  (src1_ready),
    .in_last   (src1_last),
    .in_user   (src1_user),
    .out_data  (up1_data),
    .out_keep  (up1_keep),
    .out_valid (up1_valid),
    .out_ready (up1_ready),
    .out_last  (up1_last),
    .out_user  (up1_user)
  );

  packet_arbiter packet_arbiter_i (
    .clk      (clk),
    .rst      (rst),
    .s0_data  (up0_data),
    .s0_keep  (up0_keep),
    .s0_valid (up0_valid),
    .s0_ready (up0_ready),
    .s0_last  (up0_last),
    .s0_user  (up0_user),
    .s1_data  (up1_data),
    .s1_keep  (up1_keep),
    .s1_valid (up1_valid),
    .s1_ready (up1_ready),
    .s1_last  (up1_last),
    .s1_user  (up1_user),
    .m_data   (arb_data),
    .m_keep   (arb_keep),
    .m_valid  (arb_valid),
    .m_ready  (arb_ready),
    .m_last   (arb_last),
    .m_user   (arb_user),
    .m_src    (arb_src)
  );

  output_skid output_skid_i (
    .clk       (clk),
    .rst       (rst),
    .in_data   (arb_data),
    .in_keep   (arb_keep),
    .in_valid  (arb_valid),
    .in_ready  (arb_ready),
    .in_last   (arb_last),
    .in_user   (arb_user),
    .in_src    (arb_src),
    .out_data  (out_data),
    .out_keep  (out_keep),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_last  (out_last),
    .out_user  (out_user),
    .out_src   (out_src)
  );

endmodule

/* tb/merge_checker.sv */
`timescale 1ns/1ps

module merge_checker (
  input  logic                                        clk,
  input  logic                                        rst,
  input  logic [stream_pkg::byte_width-1:0]           src0_data,
  input  logic                                        src0_valid,
  input  logic                                        src0_ready,
  input  logic                                        src0_last,
  input  logic                                        src0_user,
  input  logic [stream_pkg::byte_width-1:0]           src1_data,
  input  logic                                        src1_valid,
  input  logic                                        src1_ready,
  input  logic                                        src1_last,
  input  logic                                        src1_user,
  input  logic [stream_pkg::word_width-1:0]           out_data,
  input  logic [stream_pkg::word_bytes-1:0]           out_keep,
  input  logic                                        out_valid,
  input  logic                                        out_ready,
  input  logic                                        out_last,
  input  logic                                        out_user,
  input  logic [$clog2(stream_pkg::num_sources)-1:0]  out_src,
  input  logic                                        end_check,
  input  int                                          expected_packets,
  output int                                          packets_seen,
  output int                                          value_errors,
  output int                                          other_errors,
  output logic                                        end_done
);

  // Expected entry is {last, user, keep, data}.
  logic [stream_pkg::word_width+stream_pkg::word_bytes+1:0] exp0_q [$];
  logic [stream_pkg::word_width+stream_pkg::word_bytes+1:0] exp1_q [$];
  logic [stream_pkg::word_width-1:0]          acc_data [stream_pkg::num_sources];
  logic [stream_pkg::word_bytes-1:0]          acc_keep [stream_pkg::num_sources];
  int                                         acc_count [stream_pkg::num_sources];
  int                                         packets_in;
  logic                                       in_packet;
  logic [$clog2(stream_pkg::num_sources)-1:0] cur_src;
  logic                                       rst_d;

  // Packs accepted bytes in lane order, closing on the fourth byte or on last.
  task automatic take_byte(input int s, input logic [stream_pkg::byte_width-1:0] d,
                           input logic last, input logic user);
    logic [stream_pkg::word_width+stream_pkg::word_bytes+1:0] entry;
    acc_data[s][acc_count[s]*stream_pkg::byte_width +: stream_pkg::byte_width] = d;
    acc_keep[s][acc_count[s]] = 1'b1;
    acc_count[s] = acc_count[s] + 1;
    if (last || acc_count[s] == stream_pkg::word_bytes) begin
      entry = {last, last & user, acc_keep[s], acc_data[s]};
      if (s == 0) begin
        exp0_q.push_back(entry);
      end else begin
        exp1_q.push_back(entry);
      end
      acc_data[s]  = '0;
      acc_keep[s]  = '0;
      acc_count[s] = 0;
      if (last) begin
        packets_in++;
      end
    end
  endtask

  task automatic check_word();
    logic [stream_pkg::word_width+stream_pkg::word_bytes+1:0] entry;
    logic [stream_pkg::word_width-1:0]                        mask;
    logic [stream_pkg::word_width-1:0]                        exp_data;
    logic [stream_pkg::word_bytes-1:0]                        exp_keep;
    logic                                                     have;
    have = 1'b0;
    entry = '0;
    if (in_packet && out_src != cur_src) begin
      other_errors++;
      $display("Source %0d word interleaved into open packet of source %0d", out_src, cur_src);
    end
    in_packet = !out_last;
    cur_src   = out_src;
    if (out_last) begin
      packets_seen++;
    end
    if (out_src == '0 && exp0_q.size() > 0) begin
      entry = exp0_q.pop_front();
      have  = 1'b1;
    end else if (out_src != '0 && exp1_q.size() > 0) begin
      entry = exp1_q.pop_front();
      have  = 1'b1;
    end
    if (!have) begin
      other_errors++;
      $display("Source %0d sent a word that no accepted input bytes account for", out_src);
    end else begin
      exp_data = entry[stream_pkg::word_width-1:0];
      exp_keep = entry[stream_pkg::word_width +: stream_pkg::word_bytes];
      for (int i = 0; i < stream_pkg::word_bytes; i++) begin
        mask[i*stream_pkg::byte_width +: stream_pkg::byte_width] =
          {stream_pkg::byte_width{exp_keep[i]}};
      end
      if (out_keep !== exp_keep) begin
        value_errors++;
        $display("[FAIL] out_keep src %0d got %h expected %h", out_src, out_keep, exp_keep);
      end
      if ((out_data & mask) !== (exp_data & mask)) begin
        value_errors++;
        $display("[FAIL] out_data src %0d got %h expected %h", out_src, out_data & mask,
                 exp_data & mask);
      end
      if (out_last !== entry[stream_pkg::word_width+stream_pkg::word_bytes+1]) begin
        value_errors++;
        $display("[FAIL] out_last src %0d got %h expected %h", out_src, out_last,
                 entry[stream_pkg::word_width+stream_pkg::word_bytes+1]);
      end
      if (out_user !== entry[stream_pkg::word_width+stream_pkg::word_bytes]) begin
        value_errors++;
        $display("[FAIL] out_user src %0d got %h expected %h", out_src, out_user,
                 entry[stream_pkg::word_width+stream_pkg::word_bytes]);
      end
    end
  endtask

  task automatic check_leftovers();
    if (exp0_q.size() != 0 || exp1_q.size() != 0) begin
      other_errors++;
      $display("Words never came out, %0d from source 0 and %0d from source 1",
               exp0_q.size(), exp1_q.size());
    end
    if (acc_count[0] != 0 || acc_count[1] != 0) begin
      other_errors++;
      $display("Accepted bytes were left in a word that never closed");
    end
    if (packets_in != expected_packets || packets_seen != expected_packets) begin
      other_errors++;
      $display("Packet count wrong, %0d sent, %0d accepted, %0d seen at the output",
               expected_packets, packets_in, packets_seen);
    end
    if (in_packet) begin
      other_errors++;
      $display("Output stopped in the middle of a packet");
    end
  endtask

  always @(posedge clk) begin
    if (rst) begin
      exp0_q.delete();
      exp1_q.delete();
      for (int s = 0; s < stream_pkg::num_sources; s++) begin
        acc_data[s]  = '0;
        acc_keep[s]  = '0;
        acc_count[s] = 0;
      end
      packets_in   = 0;
      packets_seen = 0;
      value_errors = 0;
      other_errors = 0;
      in_packet    = 1'b0;
      cur_src      = '0;
      end_done     = 1'b0;
    end else begin
      if (src0_valid && src0_ready) begin
        take_byte(0, src0_data, src0_last, src0_user);
      end
      if (src1_valid && src1_ready) begin
        take_byte(1, src1_data, src1_last, src1_user);
      end
      if (out_valid && out_ready) begin
        check_word();
      end
      if (end_check && !end_done) begin
        check_leftovers();
        end_done = 1'b1;
      end
    end
    // Low through reset and one cycle beyond.
    if (rst_d && out_valid !== 1'b0) begin
      value_errors++;
      $display("[FAIL] out_valid near reset got %h expected 0", out_valid);
    end
    rst_d = rst;
  end

endmodule

/* tb/merge_tb.sv */
`timescale 1ns/1ps

module merge_tb;

  localparam int packets_per_source = 40;
  localparam int max_len            = 13;
  localparam int stall_factor       = 6;
  localparam int total_packets      = 2 * packets_per_source;
  // Worst case bytes times stall, plus margin.
  localparam int cycle_limit        = total_packets * max_len * stall_factor + 500;

  logic                                       clk;
  logic                                       rst;
  logic [stream_pkg::byte_width-1:0]          s_data [2];
  logic [1:0]                                 s_valid;
  logic [1:0]                                 s_ready;
  logic [1:0]                                 s_last;
  logic [1:0]                                 s_user;
  logic [stream_pkg::word_width-1:0]          out_data;
  logic [stream_pkg::word_bytes-1:0]          out_keep;
  logic                                       out_valid;
  logic                                       out_ready;
  logic                                       out_last;
  logic                                       out_user;
  logic [$clog2(stream_pkg::num_sources)-1:0] out_src;
  logic                                       end_check;
  logic                                       end_done;
  int                                         packets_seen;
  int                                         value_errors;
  int                                         other_errors;
  int                                         cycle_count = 0;
  bit                                         timed_out = 1'b0;

  dual_stream_merge dual_stream_merge_i (
    .clk        (clk),
    .rst        (rst),
    .src0_data  (s_data[0]),
    .src0_valid (s_valid[0]),
    .src0_ready (s_ready[0]),
    .src0_last  (s_last[0]),
    .src0_user  (s_user[0]),
    .src1_data  (s_data[1]),
    .src1_valid (s_valid[1]),
    .src1_ready (s_ready[1]),
    .src1_last  (s_last[1]),
    .src1_user  (s_user[1]),
    .out_data   (out_data),
    .out_keep   (out_keep),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_last   (out_last),
    .out_user   (out_user),
    .out_src    (out_src)
  );

  merge_checker merge_checker_i (
    .clk              (clk),
    .rst              (rst),
    .src0_data        (s_data[0]),
    .src0_valid       (s_valid[0]),
    .src0_ready       (s_ready[0]),
    .src0_last        (s_last[0]),
    .src0_user        (s_user[0]),
    .src1_data        (s_data[1]),
    .src1_valid       (s_valid[1]),
    .src1_ready       (s_ready[1]),
    .src1_last        (s_last[1]),
    .src1_user        (s_user[1]),
    .out_data         (out_data),
    .out_keep         (out_keep),
    .out_valid        (out_valid),
    .out_ready        (out_ready),
    .out_last         (out_last),
    .out_user         (out_user),
    .out_src          (out_src),
    .end_check        (end_check),
    .expected_packets (total_packets),
    .packets_seen     (packets_seen),
    .value_errors     (value_errors),
    .other_errors     (other_errors),
    .end_done         (end_done)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Random packets with idle gaps between bytes.
  task automatic send_packets(input int s);
    int len;
    for (int p = 0; p < packets_per_source; p++) begin
      len = $urandom_range(max_len, 1);
      for (int b = 0; b < len; b++) begin
        if ($urandom_range(3) == 0) begin
          s_valid[s] = 1'b0;
          repeat ($urandom_range(3, 1)) @(posedge clk);
          #1;
        end
        s_data[s]  = 8'($urandom_range(255));
        s_last[s]  = (b == len - 1);
        s_user[s]  = 1'($urandom_range(1));
        s_valid[s] = 1'b1;
        do @(posedge clk); while (!s_ready[s]);
        #1;
      end
    end
    s_valid[s] = 1'b0;
    s_last[s]  = 1'b0;
  endtask

  initial begin
    void'($urandom(60));
    rst       = 1'b1;
    s_data[0] = '0;
    s_data[1] = '0;
    s_valid   = '0;
    s_last    = '0;
    s_user    = '0;
    out_ready = 1'b0;
    end_check = 1'b0;
    repeat (2) @(posedge clk);
    #1 rst = 1'b0;
    fork
      send_packets(0);
      send_packets(1);
    join_none
    while (packets_seen < total_packets && !timed_out) begin
      @(posedge clk);
      #1;
    end
    end_check = 1'b1;
    while (!end_done) begin
      @(posedge clk);
      #1;
    end
    $display("Error counts: %0d value, %0d other, %0d timeout", value_errors, other_errors,
             int'(timed_out));
    if (value_errors == 0 && other_errors == 0 && !timed_out) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // Output back-pressure is low about 30% of cycles.
  initial begin
    @(negedge rst);
    forever begin
      @(posedge clk);
      #1;
      out_ready = ($urandom_range(99) >= 30);
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count == cycle_limit) begin
      timed_out = 1'b1;
      $display("Timeout after %0d cycles with %0d of %0d packets seen at the output",
               cycle_count, packets_seen, total_packets);
    end
  end

endmodule

/* vlog.f */
logic/stream_pkg.sv
logic/stream_upsizer.sv
logic/packet_arbiter.sv
logic/output_skid.sv
logic/dual_stream_merge.sv
tb/merge_checker.sv
tb/merge_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= merge_tb
FILELIST  ?= vlog.f

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q '^No errors$$'

clean:
	rm -rf obj_dir
